// ==== design/muldiv_msg_pkg.sv ====
// ----------------------------
// request and response message types for the multiply/divide unit
// imported by the top level, the divider and the testbench
// ----------------------------

package muldiv_msg_pkg;

  // ----------------------------
  // payload widths
  // ----------------------------

  // one source operand of a request
  typedef logic [31:0] operand_t;

  // one half of a divide response, quotient or remainder
  typedef logic [31:0] half_t;

  // full response word
  // divide: remainder in [63:32], quotient in [31:0]
  // multiply: signed 64-bit product
  typedef logic [63:0] result_t;

  // ----------------------------
  // function codes
  // ----------------------------

  typedef logic [1:0] muldiv_fn_t;

  // signed product of a and b
  localparam muldiv_fn_t FN_MUL  = 2'd0;
  // signed divide, quotient sign is xor of operand signs
  localparam muldiv_fn_t FN_DIV  = 2'd1;
  // unsigned divide, no sign handling at all
  localparam muldiv_fn_t FN_DIVU = 2'd2;

  // code 3 is unused and is routed like FN_MUL by the top level

endpackage

// ==== design/muldiv_seq_pkg.sv ====
// ----------------------------
// sequencing types shared by the iterative multiplier and divider
// ----------------------------

package muldiv_seq_pkg;

  // accept in IDLE, iterate in CALC, hold result in DONE
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } iter_state_t;

  // one step per operand bit
  typedef logic [4:0] iter_count_t;

  // count value of the final CALC cycle, 32 steps in total
  localparam iter_count_t ITER_LAST = 5'd31;

endpackage

// ==== design/int_div_dpath.sv ====
// ----------------------------
// restoring divider datapath, 32 by 32 bits
// steered by int_div_ctrl through enables and selects
// ----------------------------

`timescale 1ns/1ps

module int_div_dpath import muldiv_msg_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  // request payload, sampled on the accepting edge
  input  muldiv_fn_t req_fn,
  input  operand_t   req_a,
  input  operand_t   req_b,

  // from control
  input  logic       a_en,
  input  logic       b_en,
  input  logic       a_mux_sel,
  input  logic       sign_en,

  // trial subtraction went negative
  output logic       sub_neg,
  output result_t    result
);

  // ----------------------------
  // operand magnitudes
  // ----------------------------

  logic  is_signed;
  half_t a_mag;
  half_t b_mag;

  // only signed divide strips the signs, DIVU uses the raw bits
  assign is_signed = (req_fn == FN_DIV);
  // -2^31 still fits as an unsigned magnitude
  assign a_mag = (is_signed && req_a[31]) ? -req_a : req_a;
  assign b_mag = (is_signed && req_b[31]) ? -req_b : req_b;

  // ----------------------------
  // registers
  // ----------------------------

  // remainder/quotient register
  // quotient bits enter at the bottom, remainder ends up in [63:32]
  logic [64:0] rq_reg;
  // divisor aligned with the remainder half
  logic [64:0] div_reg;
  logic        quot_neg;
  logic        rem_neg;

  logic [64:0] rq_shift;
  logic [64:0] rq_diff;
  logic [64:0] rq_step;
  logic [64:0] rq_next;

  // one shift-subtract step
  assign rq_shift = rq_reg << 1;
  assign rq_diff  = rq_shift - div_reg;
  // bit 64 is the borrow of the trial subtraction
  assign sub_neg  = rq_diff[64];
  // restore keeps the shifted value, its low bit is already a zero quotient bit
  assign rq_step  = sub_neg ? rq_shift : {rq_diff[64:1], 1'b1};

  // load the dividend or take a step
  assign rq_next  = a_mux_sel ? rq_step : {33'b0, a_mag};

  always_ff @(posedge clk) begin
    if (a_en) begin
      rq_reg <= rq_next;
    end
    if (b_en) begin
      div_reg <= {1'b0, b_mag, 32'b0};
    end
  end

  // sign flags only ever set for FN_DIV
  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (sign_en) begin
      quot_neg <= is_signed && (req_a[31] ^ req_b[31]);
      // remainder follows the dividend
      rem_neg  <= is_signed && req_a[31];
    end
  end

  // ----------------------------
  // output sign fixup
  // ----------------------------

  half_t quot_mag;
  half_t rem_mag;

  assign quot_mag = rq_reg[31:0];
  assign rem_mag  = rq_reg[63:32];

  assign result = {rem_neg  ? -rem_mag  : rem_mag,
                   quot_neg ? -quot_mag : quot_mag};

endmodule

// ==== design/int_div_ctrl.sv ====
// ----------------------------
// divider control FSM
// counts 32 CALC cycles and drives the datapath enables
// ----------------------------

`timescale 1ns/1ps

module int_div_ctrl import muldiv_seq_pkg::*; (
  input  logic clk,
  input  logic reset,

  // handshakes
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,

  // datapath controls
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sign_en
);

  iter_state_t state;
  iter_count_t count;

  logic accept;
  logic send;

  assign accept = req_val && req_rdy;
  assign send   = resp_val && resp_rdy;

  // ----------------------------
  // state and counter
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // last step lands on the edge that leaves CALC
          if (count == ITER_LAST) begin
            state <= DONE;
          end else begin
            count <= count + 5'd1;
          end
        end
        DONE: begin
          if (send) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ----------------------------
  // outputs from current state
  // ----------------------------

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    b_en      = 1'b0;
    a_mux_sel = 1'b0;
    sign_en   = 1'b0;
    case (state)
      IDLE: begin
        req_rdy = 1'b1;
        // load operands and signs on the accepting edge
        a_en    = req_val;
        b_en    = req_val;
        sign_en = req_val;
      end
      CALC: begin
        // one shift-subtract step per cycle
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
      end
      DONE: begin
        resp_val = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== design/int_div_iterative.sv ====
// ----------------------------
// iterative divider, joins datapath and control
// one request in flight, result valid 32 cycles after acceptance
// ----------------------------

`timescale 1ns/1ps

module int_div_iterative import muldiv_msg_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  input  logic       req_val,
  output logic       req_rdy,
  input  muldiv_fn_t req_fn,
  input  operand_t   req_a,
  input  operand_t   req_b,

  output logic       resp_val,
  input  logic       resp_rdy,
  output result_t    resp_result
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sign_en;

  // the restore decision is made inside the datapath
  int_div_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .req_fn    (req_fn),
    .req_a     (req_a),
    .req_b     (req_b),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .sign_en   (sign_en),
    .sub_neg   (),
    .result    (resp_result)
  );

  int_div_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .resp_rdy  (resp_rdy),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .sign_en   (sign_en)
  );

endmodule

// ==== design/int_mul_iterative.sv ====
// ----------------------------
// iterative signed shift-add multiplier, 32 x 32 to 64 bits
// same IDLE/CALC/DONE timing as the divider
// ----------------------------

`timescale 1ns/1ps

module int_mul_iterative import muldiv_msg_pkg::*, muldiv_seq_pkg::*; (
  input  logic     clk,
  input  logic     reset,

  input  logic     req_val,
  output logic     req_rdy,
  input  operand_t req_a,
  input  operand_t req_b,

  output logic     resp_val,
  input  logic     resp_rdy,
  output result_t  resp_result
);

  iter_state_t state;
  iter_count_t count;

  logic accept;
  logic send;

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign accept   = req_val && req_rdy;
  assign send     = resp_val && resp_rdy;

  // ----------------------------
  // sequencing
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          if (count == ITER_LAST) begin
            state <= DONE;
          end else begin
            count <= count + 5'd1;
          end
        end
        DONE: begin
          if (send) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ----------------------------
  // datapath
  // ----------------------------

  operand_t a_mag;
  operand_t b_mag;

  // magnitudes, -2^31 maps to 2^31 unsigned
  assign a_mag = req_a[31] ? -req_a : req_a;
  assign b_mag = req_b[31] ? -req_b : req_b;

  // multiplicand moves left, multiplier right
  result_t  mcand_reg;
  operand_t mplier_reg;
  result_t  prod_reg;
  logic     neg_reg;

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand_reg  <= {32'b0, a_mag};
      mplier_reg <= b_mag;
      prod_reg   <= '0;
      neg_reg    <= req_a[31] ^ req_b[31];
    end else if (state == CALC) begin
      // add in the partial product for the current multiplier bit
      if (mplier_reg[0]) begin
        prod_reg <= prod_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // sign applied at the output, stays valid while held in DONE
  assign resp_result = neg_reg ? -prod_reg : prod_reg;

endmodule

// ==== design/int_muldiv_unit.sv ====
// ----------------------------
// multiply/divide unit top level
// routes requests by function code, responses return in request order
// ----------------------------

`timescale 1ns/1ps

module int_muldiv_unit import muldiv_msg_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  input  logic       req_val,
  input  muldiv_fn_t req_fn,
  input  operand_t   req_a,
  input  operand_t   req_b,
  output logic       req_rdy,

  output logic       resp_val,
  output result_t    resp_result,
  input  logic       resp_rdy
);

  // ----------------------------
  // request routing
  // ----------------------------

  logic    is_mul;
  logic    q_full;
  logic    q_empty;
  logic    mul_req_rdy;
  logic    div_req_rdy;
  logic    mul_resp_val;
  logic    div_resp_val;
  logic    mul_resp_rdy;
  logic    div_resp_rdy;
  result_t mul_result;
  result_t div_result;

  // both divide codes go to the divider, the rest to the multiplier
  assign is_mul  = (req_fn == FN_MUL) || (req_fn == 2'd3);
  assign req_rdy = (is_mul ? mul_req_rdy : div_req_rdy) && !q_full;

  int_mul_iterative mul0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val && is_mul && !q_full),
    .req_rdy     (mul_req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_result)
  );

  int_div_iterative div0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val && !is_mul && !q_full),
    .req_rdy     (div_req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_result)
  );

  // ----------------------------
  // order queue of unit tags
  // ----------------------------

  // tag 1 marks the divider
  logic       tag_q [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] q_count;
  logic       push;
  logic       pop;
  logic       head_is_div;

  assign q_full      = (q_count == 2'd2);
  assign q_empty     = (q_count == 2'd0);
  assign push        = req_val && req_rdy;
  assign pop         = resp_val && resp_rdy;
  assign head_is_div = tag_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      tag_q[wr_ptr] <= !is_mul;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      q_count <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      // push and pop together leave the count alone
      q_count <= q_count + {1'b0, push} - {1'b0, pop};
    end
  end

  // ----------------------------
  // response selection
  // ----------------------------

  // only the unit at the head may hand over its result
  assign resp_val     = !q_empty && (head_is_div ? div_resp_val : mul_resp_val);
  assign resp_result  = head_is_div ? div_result : mul_result;
  assign mul_resp_rdy = resp_rdy && !q_empty && !head_is_div;
  assign div_resp_rdy = resp_rdy && !q_empty && head_is_div;

endmodule

// ==== tb/int_muldiv_properties.sv ====
// ------------------------------
// handshake assertions, bound into the top level
// ------------------------------

`timescale 1ns/1ps

module int_muldiv_properties import muldiv_msg_pkg::*; (
  input logic    clk,
  input logic    reset,
  input logic    req_rdy,
  input logic    resp_val,
  input logic    resp_rdy,
  input result_t resp_result
);

  // a stalled response keeps its valid and its data
  property resp_held;
    @(posedge clk) disable iff (reset)
      (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result));
  endproperty

  // nothing in flight out of reset
  property resp_idle_after_reset;
    @(posedge clk) reset |=> !resp_val;
  endproperty

  // both units idle and the order queue empty
  property req_ready_after_reset;
    @(posedge clk) reset |=> req_rdy;
  endproperty

  resp_held_a: assert property (resp_held)
    else $error("response changed while stalled");
  resp_idle_a: assert property (resp_idle_after_reset)
    else $error("resp_val high right after reset");
  req_ready_a: assert property (req_ready_after_reset)
    else $error("req_rdy low right after reset");

endmodule

bind int_muldiv_unit int_muldiv_properties props0 (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

// ==== tb/int_muldiv_tb.sv ====
// ------------------------------
// directed and random testbench for the multiply/divide unit
// every response is compared with a reference model in request order
// ------------------------------

`timescale 1ns/1ps

module int_muldiv_tb import muldiv_msg_pkg::*; ();

  localparam int CLK_HALF       = 20;
  localparam int DRIVE_DLY      = 2;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RAND_OPS       = 200;

  logic       clk;
  logic       reset;
  logic       req_val;
  muldiv_fn_t req_fn;
  operand_t   req_a;
  operand_t   req_b;
  logic       req_rdy;
  logic       resp_val;
  result_t    resp_result;
  logic       resp_rdy;

  // values seen just before the last rising edge
  logic    s_req_rdy;
  logic    s_resp_val;
  logic    req_done;
  logic    resp_done;
  result_t s_result;

  // rising edges since time zero, also drives the timeout
  int cycles;

  // requests still to send and responses still to come, oldest first
  muldiv_fn_t pend_fn[$];
  operand_t   pend_a[$];
  operand_t   pend_b[$];
  result_t    exp_q[$];
  int         acc_cyc[$];
  int         rsp_cyc[$];

  int value_errs;
  int flag_errs;
  int event_errs;

  int_muldiv_unit dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------

  // divide on magnitudes, then quotient sign = xor, remainder sign = dividend
  // a zero divisor gives an all ones quotient magnitude and remainder |a|
  function automatic result_t model_result(muldiv_fn_t fn, operand_t a, operand_t b);
    longint prod;
    logic   neg_a;
    logic   neg_b;
    half_t  a_mag;
    half_t  b_mag;
    half_t  q_mag;
    half_t  r_mag;
    half_t  quot;
    half_t  rem;
    if (fn != FN_DIV && fn != FN_DIVU) begin
      prod = longint'($signed(a)) * longint'($signed(b));
      return result_t'(prod);
    end
    neg_a = (fn == FN_DIV) && a[31];
    neg_b = (fn == FN_DIV) && b[31];
    a_mag = neg_a ? (~a + 32'd1) : a;
    b_mag = neg_b ? (~b + 32'd1) : b;
    if (b_mag == 32'd0) begin
      q_mag = 32'hFFFFFFFF;
      r_mag = a_mag;
    end else begin
      q_mag = a_mag / b_mag;
      r_mag = a_mag % b_mag;
    end
    quot = (neg_a ^ neg_b) ? (~q_mag + 32'd1) : q_mag;
    rem  = neg_a ? (~r_mag + 32'd1) : r_mag;
    return {rem, quot};
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_result(input string name, input result_t got, input result_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail %s: got 0x%h expected 0x%h at edge %0d", name, got, exp, cycles);
    end
  endtask

  task automatic check_rdy(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("Fail %s: got 0x%h expected 0x%h at edge %0d", name, got, exp, cycles);
    end
  endtask

  task automatic check_val(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("Fail %s: got 0x%h expected 0x%h at edge %0d", name, got, exp, cycles);
    end
  endtask

  // ------------------------------
  // cycle stepping and traffic
  // ------------------------------

  // sample at the falling edge, then return to the drive point of the next cycle
  task automatic next_cycle();
    @(negedge clk);
    s_req_rdy  = req_rdy;
    s_resp_val = resp_val;
    s_result   = resp_result;
    req_done   = req_val && req_rdy;
    resp_done  = resp_val && resp_rdy;
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic add_op_exp(muldiv_fn_t fn, operand_t a, operand_t b, result_t exp);
    pend_fn.push_back(fn);
    pend_a.push_back(a);
    pend_b.push_back(b);
    exp_q.push_back(exp);
  endtask

  task automatic add_op(muldiv_fn_t fn, operand_t a, operand_t b);
    add_op_exp(fn, a, b, model_result(fn, a, b));
  endtask

  // sends all pending requests and drains all expected responses
  // stall_pct is the chance in percent of resp_rdy low in a cycle
  task automatic run_traffic(input int stall_pct);
    acc_cyc.delete();
    rsp_cyc.delete();
    while (exp_q.size() > 0) begin
      req_val = (pend_fn.size() > 0);
      if (pend_fn.size() > 0) begin
        req_fn = pend_fn[0];
        req_a  = pend_a[0];
        req_b  = pend_b[0];
      end
      resp_rdy = (int'($urandom_range(99, 0)) >= stall_pct);
      next_cycle();
      if (req_done) begin
        void'(pend_fn.pop_front());
        void'(pend_a.pop_front());
        void'(pend_b.pop_front());
        acc_cyc.push_back(cycles);
      end
      if (resp_done) begin
        check_result("resp_result", s_result, exp_q.pop_front());
        rsp_cyc.push_back(cycles);
      end
    end
    req_val  = 1'b0;
    resp_rdy = 1'b1;
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic test_divu();
    next_cycle();
    check_rdy("req_rdy", s_req_rdy, 1'b1);
    check_val("resp_val", s_resp_val, 1'b0);
    add_op(FN_DIVU, 32'd100, 32'd7);
    run_traffic(0);
    if (rsp_cyc[0] - acc_cyc[0] != 33) begin
      event_errs++;
      $display("Error: divide answered %0d edges after acceptance instead of 33",
               rsp_cyc[0] - acc_cyc[0]);
    end
    add_op(FN_DIVU, 32'hFFFFFFFF, 32'd3);
    add_op(FN_DIVU, 32'd5, 32'd9);
    add_op(FN_DIVU, 32'h80000000, 32'hFFFFFFFF);
    // zero divisor, quotient all ones and remainder equal to a
    add_op_exp(FN_DIVU, 32'hCAFE0001, 32'd0, {32'hCAFE0001, 32'hFFFFFFFF});
    run_traffic(0);
  endtask

  task automatic test_div_signs();
    add_op(FN_DIV, 32'd7, 32'd2);
    add_op(FN_DIV, operand_t'(-7), 32'd2);
    add_op(FN_DIV, 32'd7, operand_t'(-2));
    add_op(FN_DIV, operand_t'(-7), operand_t'(-2));
    add_op(FN_DIV, 32'h80000000, operand_t'(-1));
    add_op(FN_DIV, operand_t'(-123456), 32'd0);
    run_traffic(0);
  endtask

  task automatic test_mul();
    add_op(FN_MUL, 32'd3, 32'd4);
    add_op(FN_MUL, operand_t'(-3), 32'd4);
    add_op(FN_MUL, 32'd3, operand_t'(-4));
    add_op(FN_MUL, operand_t'(-3), operand_t'(-4));
    add_op(FN_MUL, 32'h7FFFFFFF, 32'h7FFFFFFF);
    add_op(FN_MUL, 32'h80000000, 32'h80000000);
    add_op(FN_MUL, 32'h80000000, 32'h7FFFFFFF);
    add_op(FN_MUL, 32'hFFFFFFFF, 32'd0);
    run_traffic(0);
  endtask

  task automatic test_backpressure();
    result_t exp;
    int      stall;
    exp      = model_result(FN_MUL, 32'hDEADBEEF, 32'h00012345);
    resp_rdy = 1'b0;
    req_val  = 1'b1;
    req_fn   = FN_MUL;
    req_a    = 32'hDEADBEEF;
    req_b    = 32'h00012345;
    next_cycle();
    while (!req_done) begin
      next_cycle();
    end
    req_val = 1'b0;
    next_cycle();
    // multiplier busy while it computes
    while (!s_resp_val) begin
      check_rdy("req_rdy", s_req_rdy, 1'b0);
      next_cycle();
    end
    stall = int'($urandom_range(12, 3));
    repeat (stall) begin
      check_result("resp_result", s_result, exp);
      check_rdy("req_rdy", s_req_rdy, 1'b0);
      check_val("resp_val", s_resp_val, 1'b1);
      next_cycle();
    end
    resp_rdy = 1'b1;
    next_cycle();
    check_val("resp_val", resp_done, 1'b1);
    check_result("resp_result", s_result, exp);
    // gone after one transfer, unit free again
    next_cycle();
    check_val("resp_val", s_resp_val, 1'b0);
    check_rdy("req_rdy", s_req_rdy, 1'b1);
  endtask

  task automatic test_order();
    add_op(FN_MUL, 32'h00001234, operand_t'(-5));
    add_op(FN_DIV, operand_t'(-1000), 32'd7);
    add_op(FN_MUL, 32'h7FFFFFFF, 32'd2);
    run_traffic(0);
    if (acc_cyc[1] != acc_cyc[0] + 1) begin
      event_errs++;
      $display("Error: divide was not accepted right after the multiply");
    end
    if (acc_cyc[2] <= rsp_cyc[0]) begin
      event_errs++;
      $display("Error: third request taken at edge %0d before the first response at edge %0d",
               acc_cyc[2], rsp_cyc[0]);
    end
  endtask

  task automatic test_random();
    operand_t   a;
    operand_t   b;
    muldiv_fn_t fn;
    for (int i = 0; i < RAND_OPS; i++) begin
      case ($urandom_range(2, 0))
        0:       fn = FN_MUL;
        1:       fn = FN_DIV;
        default: fn = FN_DIVU;
      endcase
      a = $urandom();
      b = $urandom();
      // small divisors, zero and small negatives now and then
      if ($urandom_range(3, 0) == 0) begin
        b = operand_t'($urandom_range(15, 0));
        if ($urandom_range(1, 0) == 1) begin
          b = ~b + 32'd1;
        end
      end
      add_op(fn, a, b);
    end
    run_traffic(30);
  endtask

  // ------------------------------
  // run control
  // ------------------------------

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    void'($urandom(80));
    value_errs = 0;
    flag_errs  = 0;
    event_errs = 0;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_fn     = FN_MUL;
    req_a      = '0;
    req_b      = '0;
    resp_rdy   = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;
    test_divu();
    test_div_signs();
    test_mul();
    test_backpressure();
    test_order();
    test_random();
    $display("errors: %0d value, %0d handshake flag, %0d timing/order",
             value_errs, flag_errs, event_errs);
    if (value_errs + flag_errs + event_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
design/muldiv_msg_pkg.sv
design/muldiv_seq_pkg.sv
design/int_div_dpath.sv
design/int_div_ctrl.sv
design/int_div_iterative.sv
design/int_mul_iterative.sv
design/int_muldiv_unit.sv
tb/int_muldiv_properties.sv
tb/int_muldiv_tb.sv

// ==== Makefile ====
# Verilator build and run for the multiply/divide unit

VERILATOR  ?= verilator
TOP        := int_muldiv_tb
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
FAIL_MSG   := Simulation FAILED
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the log decides the result, a missing pass line counts as failure too
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
